/* run.sh */
#!/bin/sh
# Build and run the tilemap generator regression with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=simTilemapGen

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbTilemapGen -f tilemapGen.f -o "$SIM"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* src/cpuPort.sv */
`timescale 1ns/1ps
`include "tilemapGen_macros.svh"

module cpuPort import tilemapPkg::*; (
	input  logic       clk6M,
	input  logic       rstN,
	input  beamPos     hCount,
	input  logic       cpuReq,
	input  logic       cpuRegSel,
	input  logic       cpuWe,
	input  tileAddr    cpuAddr,
	input  tileWord    cpuWData,
	input  scrollX     curScrollXA,
	input  scrollY     curScrollYA,
	input  scrollX     curScrollXB,
	input  scrollY     curScrollYB,
	input  tileWord    ramRData,
	output logic       cpuAck,
	output tileWord    cpuRData,
	output tileAddr    ramAddrCpu,
	output logic       ramWeCpu,
	output tileWord    ramWDataCpu,
	output logic       scrollWeA,
	output logic       scrollWeB,
	output logic       scrollSelY,
	output logic [8:0] scrollData
);

	cpuState state;
	logic [1:0] regIdx;
	logic preSlot;
	logic regWrite;
	tileWord regRData;

	// Slot just before the CPU slot
	assign preSlot = (hCount[1:0] == `SLOT_CPU - 2'd1);

	//////////////////////////////////////////////////
	// Register decode
	//////////////////////////////////////////////////

	assign regIdx = cpuAddr[1:0];
	assign regWrite = (state == access) && cpuRegSel && cpuWe;

	// One strobe per layer, Y select shared
	assign scrollWeA = regWrite && (regIdx == `REG_SCROLL_XA || regIdx == `REG_SCROLL_YA);
	assign scrollWeB = regWrite && (regIdx == `REG_SCROLL_XB || regIdx == `REG_SCROLL_YB);
	assign scrollSelY = (regIdx == `REG_SCROLL_YA || regIdx == `REG_SCROLL_YB);
	assign scrollData = cpuWData[8:0];

	// Readback, zero extended
	always_comb begin
		case (regIdx)
			`REG_SCROLL_XA: regRData = {7'd0, curScrollXA};
			`REG_SCROLL_YA: regRData = {8'd0, curScrollYA};
			`REG_SCROLL_XB: regRData = {7'd0, curScrollXB};
			default:        regRData = {8'd0, curScrollYB};
		endcase
	end

	// RAM side, forwarded by the top in the CPU slot
	assign ramAddrCpu = cpuAddr;
	assign ramWDataCpu = cpuWData;
	assign ramWeCpu = (state == access) && !cpuRegSel && cpuWe;

	//////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			cpuAck <= 1'b0;
		end else begin
			case (state)
				// Skip the wait when the slot is next
				idle: if (cpuReq) state <= preSlot ? access : waitSlot;
				waitSlot: if (preSlot) state <= access;
				access: begin
					// RAM reads need one more cycle for data
					if (cpuRegSel || cpuWe) begin
						cpuAck <= 1'b1;
						state <= ackHold;
					end else begin
						state <= capture;
					end
				end
				capture: begin
					cpuAck <= 1'b1;
					state <= ackHold;
				end
				// Held until the CPU releases, no second access
				ackHold: begin
					if (!cpuReq) begin
						cpuAck <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Read data, stable while cpuAck is high
	always_ff @(posedge clk6M) begin
		if (state == access && cpuRegSel)
			cpuRData <= regRData;
		else if (state == capture)
			cpuRData <= ramRData;
	end

	assert property (@(posedge clk6M) disable iff (!rstN)
		$rose(cpuAck) |-> ($past(state) == access || $past(state) == capture));
	assert property (@(posedge clk6M) disable iff (!rstN)
		ramWeCpu |-> hCount[1:0] == `SLOT_CPU);

endmodule

/* src/tileLayer.sv */
`timescale 1ns/1ps

module tileLayer import tilemapPkg::*; #(
	parameter int layerId = 0
) (
	input  logic       clk6M,
	input  logic       rstN,
	input  beamPos     hCount,
	input  beamPos     vCount,
	input  logic       flip,
	input  logic       scrollWe,
	input  logic       scrollSelY,
	input  logic [8:0] scrollData,
	input  tileWord    ramRData,
	output tileAddr    fetchAddr,
	output scrollX     curScrollX,
	output scrollY     curScrollY,
	output gfxAddr     gfxAddrOut,
	output colorCode   color,
	output logic       valid
);

	// Fetch slot of this layer and the slot of its result
	localparam logic [1:0] fetchSlot = 2'(layerId);
	localparam logic [1:0] validSlot = 2'(layerId + 2);
	// Layer bit of the tile RAM address
	localparam logic layerBit = layerId[0];

	scrollX scrollXReg;
	scrollY scrollYReg;
	logic [8:0] sumX;
	logic [7:0] sumY;
	logic [8:0] effX;
	logic [7:0] effY;
	logic inSlot;
	logic slotD1;
	logic [2:0] fineRowD1;

	//////////////////////////////////////////////////
	// Scroll registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			scrollXReg <= '0;
			scrollYReg <= '0;
		end else if (scrollWe) begin
			// Y takes the low byte only
			if (scrollSelY)
				scrollYReg <= scrollData[7:0];
			else
				scrollXReg <= scrollData;
		end
	end

	// Readback to the CPU port
	assign curScrollX = scrollXReg;
	assign curScrollY = scrollYReg;

	//////////////////////////////////////////////////
	// Stage 0: tile address
	//////////////////////////////////////////////////

	// Wraps at 512 in X and 256 in Y
	assign sumX = hCount + scrollXReg;
	assign sumY = vCount[7:0] + scrollYReg;

	// Screen flip mirrors both axes
	assign effX = flip ? ~sumX : sumX;
	assign effY = flip ? ~sumY : sumY;

	// Row from effY[7:3], column from effX[8:3]
	assign fetchAddr = {layerBit, effY[7:3], effX[8:3]};

	assign inSlot = (hCount[1:0] == fetchSlot);

	//////////////////////////////////////////////////
	// Stage 1: tile word returns
	//////////////////////////////////////////////////

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN)
			slotD1 <= 1'b0;
		else
			slotD1 <= inSlot;
	end

	// Fine row taken with the address, held across the RAM cycle
	always_ff @(posedge clk6M) begin
		if (inSlot)
			fineRowD1 <= effY[2:0];
	end

	//////////////////////////////////////////////////
	// Stage 2: graphics address
	//////////////////////////////////////////////////

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN)
			valid <= 1'b0;
		else
			valid <= slotD1;
	end

	always_ff @(posedge clk6M) begin
		if (slotD1) begin
			// Code bits 15 to 5, color bits 4 to 0
			gfxAddrOut <= {ramRData[15:5], fineRowD1};
			color <= ramRData[4:0];
		end
	end

	// Result lands two slots after the fetch
	assert property (@(posedge clk6M) disable iff (!rstN)
		valid |-> hCount[1:0] == validSlot);

endmodule

/* src/tilemapGen.sv */
`timescale 1ns/1ps
`include "tilemapGen_macros.svh"

module tilemapGen import tilemapPkg::*; (
	input  logic     clk6M,
	input  logic     rstN,
	input  logic     flip,
	input  logic     cpuReq,
	input  logic     cpuRegSel,
	input  logic     cpuWe,
	input  tileAddr  cpuAddr,
	input  tileWord  cpuWData,
	input  tileWord  ramRData,
	output logic     cpuAck,
	output tileWord  cpuRData,
	output tileAddr  ramAddr,
	output logic     ramWe,
	output tileWord  ramWData,
	output beamPos   hCount,
	output beamPos   vCount,
	output logic     hSyncN,
	output logic     vSyncN,
	output gfxAddr   gfxOut,
	output colorCode colorOut,
	output logic     gfxLayer,
	output logic     gfxValid
);

	// Layer ids double as their fetch slots
	localparam int layerA = 0;
	localparam int layerB = 1;

	tileAddr fetchAddrA, fetchAddrB, ramAddrCpu;
	tileWord ramWDataCpu;
	scrollX curScrollXA, curScrollXB;
	scrollY curScrollYA, curScrollYB;
	gfxAddr gfxAddrA, gfxAddrB;
	colorCode colorA, colorB;
	logic validA, validB, ramWeCpu;
	logic scrollWeA, scrollWeB, scrollSelY;
	logic [8:0] scrollData;
	logic [1:0] slot;

	videoTiming uVideoTiming (.clk6M, .rstN, .hCount, .vCount, .hSyncN, .vSyncN);

	tileLayer #(.layerId(layerA)) uLayerA (
		.clk6M, .rstN, .hCount, .vCount, .flip, .scrollWe(scrollWeA), .scrollSelY,
		.scrollData, .ramRData, .fetchAddr(fetchAddrA), .curScrollX(curScrollXA),
		.curScrollY(curScrollYA), .gfxAddrOut(gfxAddrA), .color(colorA), .valid(validA)
	);

	tileLayer #(.layerId(layerB)) uLayerB (
		.clk6M, .rstN, .hCount, .vCount, .flip, .scrollWe(scrollWeB), .scrollSelY,
		.scrollData, .ramRData, .fetchAddr(fetchAddrB), .curScrollX(curScrollXB),
		.curScrollY(curScrollYB), .gfxAddrOut(gfxAddrB), .color(colorB), .valid(validB)
	);

	cpuPort uCpuPort (
		.clk6M, .rstN, .hCount, .cpuReq, .cpuRegSel, .cpuWe, .cpuAddr, .cpuWData,
		.curScrollXA, .curScrollYA, .curScrollXB, .curScrollYB, .ramRData, .cpuAck,
		.cpuRData, .ramAddrCpu, .ramWeCpu, .ramWDataCpu, .scrollWeA, .scrollWeB,
		.scrollSelY, .scrollData
	);

	//////////////////////////////////////////////////
	// Tile RAM slot mux
	//////////////////////////////////////////////////

	assign slot = hCount[1:0];
	assign ramWData = ramWDataCpu;

	// Slot 3 idles on layer A's address
	always_comb begin
		ramAddr = fetchAddrA;
		ramWe = 1'b0;
		case (slot)
			2'(layerB): ramAddr = fetchAddrB;
			`SLOT_CPU: begin
				ramAddr = ramAddrCpu;
				ramWe = ramWeCpu;
			end
			default: ramAddr = fetchAddrA;
		endcase
	end

	//////////////////////////////////////////////////
	// Graphics output mux
	//////////////////////////////////////////////////

	// Results fall in slots 2 and 3, never together
	assign gfxValid = validA | validB;
	assign gfxLayer = validB;
	assign gfxOut = validB ? gfxAddrB : gfxAddrA;
	assign colorOut = validB ? colorB : colorA;

	// Layer tag matches the fetch slot two cycles back
	assert property (@(posedge clk6M) disable iff (!rstN)
		gfxValid |-> $past(slot, 2) == {1'b0, gfxLayer});

endmodule

/* src/tilemapGen_macros.svh */
`ifndef TILEMAPGEN_MACROS_SVH
`define TILEMAPGEN_MACROS_SVH

//////////////////////////////////////////////////
// Raster geometry
//////////////////////////////////////////////////

// Pixels per line, a multiple of the four-slot group
`define H_TOTAL 384
// Lines per frame
`define V_TOTAL 264

// Horizontal sync window, in pixels
`define HSYNC_START 320
`define HSYNC_END 352
// Vertical sync window, in lines
`define VSYNC_START 240
`define VSYNC_END 243

//////////////////////////////////////////////////
// Tile RAM slots and scroll register map
//////////////////////////////////////////////////

// CPU slot of every four-cycle group
`define SLOT_CPU 2'd2

// Register indices, cpuAddr bits 1 to 0
`define REG_SCROLL_XA 2'd0
`define REG_SCROLL_YA 2'd1
`define REG_SCROLL_XB 2'd2
`define REG_SCROLL_YB 2'd3

`endif

/* src/tilemapPkg.sv */
package tilemapPkg;

	//////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////

	// Beam counter value
	typedef logic [8:0] beamPos;

	// Scroll offsets, full range in X, 256 lines in Y
	typedef logic [8:0] scrollX;
	typedef logic [7:0] scrollY;

	// Tile RAM address {layer, row[4:0], column[5:0]}
	typedef logic [11:0] tileAddr;

	// Tile RAM word {code[10:0], color[4:0]}
	typedef logic [15:0] tileWord;

	// Graphics ROM address {code[10:0], fineRow[2:0]}
	typedef logic [13:0] gfxAddr;

	// Tile color field
	typedef logic [4:0] colorCode;

	//////////////////////////////////////////////////
	// CPU port FSM
	//////////////////////////////////////////////////

	typedef enum logic [2:0] {
		idle,
		waitSlot,
		access,
		capture,
		ackHold
	} cpuState;

endpackage

/* src/videoTiming.sv */
`timescale 1ns/1ps
`include "tilemapGen_macros.svh"

module videoTiming import tilemapPkg::*; (
	input  logic   clk6M,
	input  logic   rstN,
	output beamPos hCount,
	output beamPos vCount,
	output logic   hSyncN,
	output logic   vSyncN
);

	logic lineEnd;
	logic frameEnd;

	// Last pixel of the line and last line of the frame
	assign lineEnd = (hCount == `H_TOTAL - 1);
	assign frameEnd = (vCount == `V_TOTAL - 1);

	//////////////////////////////////////////////////
	// Beam counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			if (lineEnd) begin
				hCount <= '0;
				// Line step only on horizontal wrap
				if (frameEnd)
					vCount <= '0;
				else
					vCount <= vCount + 1'b1;
			end else begin
				hCount <= hCount + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Sync outputs
	//////////////////////////////////////////////////

	// Registered, so both syncs trail the counters by one pixel
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			hSyncN <= 1'b1;
			vSyncN <= 1'b1;
		end else begin
			hSyncN <= !(hCount >= `HSYNC_START && hCount < `HSYNC_END);
			vSyncN <= !(vCount >= `VSYNC_START && vCount < `VSYNC_END);
		end
	end

	// Counter wraps before the line length
	assert property (@(posedge clk6M) disable iff (!rstN) hCount < `H_TOTAL);

endmodule

/* tests/clkGen.sv */
`timescale 1ns/1ps

module clkGen #(
	parameter int halfPeriod = 20,
	parameter int resetCycles = 2
) (
	output logic clk6M,
	output logic rstN
);

	// 40 ns pixel clock
	initial begin
		clk6M = 1'b0;
		forever #(halfPeriod) clk6M = ~clk6M;
	end

	// Release just after an edge, like the stimulus
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk6M);
		#2 rstN = 1'b1;
	end

endmodule

/* tests/tbTilemapGen.sv */
`timescale 1ns/1ps
`include "tilemapGen_macros.svh"

module tbTilemapGen import tilemapPkg::*; ();

	// Frame length and handshake allowance
	localparam int frameCycles = `H_TOTAL * `V_TOTAL;
	localparam int accessCount = 25;
	localparam int maxCycles = 3 * frameCycles + accessCount * 32;
	localparam int driveDelay = 2;

	logic clk6M, rstN, flip;
	logic cpuReq, cpuRegSel, cpuWe, cpuAck, ramWe;
	tileAddr cpuAddr, ramAddr;
	tileWord cpuWData, cpuRData, ramRData, ramWData;
	beamPos hCount, vCount;
	logic hSyncN, vSyncN, gfxLayer, gfxValid;
	gfxAddr gfxOut;
	colorCode colorOut;

	// Shadow scroll values indexed by layer
	scrollX shadowX [2];
	scrollY shadowY [2];
	tileWord regValue [4];

	integer seed;
	int valueErrors, protocolErrors, cycleCount, gfxChecks, weCycles, ramWrites;
	logic timedOut, checkOn;
	logic [18:0] expected;

	// Beam position one pixel back, for the registered syncs
	beamPos prevH, prevV;
	logic prevSeen, expHSyncN, expVSyncN;

	clkGen uClkGen (.clk6M, .rstN);

	tileRamModel u_ram (.clk6M, .addr(ramAddr), .we(ramWe), .wData(ramWData), .rData(ramRData));

	tilemapGen u_tilemapGen (
		.clk6M, .rstN, .flip, .cpuReq, .cpuRegSel, .cpuWe, .cpuAddr, .cpuWData, .ramRData,
		.cpuAck, .cpuRData, .ramAddr, .ramWe, .ramWData, .hCount, .vCount, .hSyncN, .vSyncN,
		.gfxOut, .colorOut, .gfxLayer, .gfxValid
	);

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// {gfx address, color} for a fetch at beam h, v
	function automatic logic [18:0] expectedFetch(input logic layer, input beamPos h,
			input beamPos v, input logic flipVal);
		logic [8:0] effX;
		logic [7:0] effY;
		tileAddr addr;
		tileWord word;
		effX = h + shadowX[layer];
		effY = v[7:0] + shadowY[layer];
		// Flip mirrors both axes
		if (flipVal) begin
			effX = ~effX;
			effY = ~effY;
		end
		addr = {layer, effY[7:3], effX[8:3]};
		word = u_ram.mem[addr];
		return {word[15:5], effY[2:0], word[4:0]};
	endfunction

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic stepCycle();
		@(posedge clk6M);
		#(driveDelay);
	endtask

	// Four-phase access with an optional hold after ack
	task automatic cpuAccess(input logic regSel, input logic we, input tileAddr addr,
			input tileWord wData, input int holdCycles, output tileWord rData);
		int waitCycles;
		stepCycle();
		assert (!cpuAck) else begin
			protocolErrors++;
			$display("cpuAck was already high before the request");
		end
		cpuReq = 1'b1;
		cpuRegSel = regSel;
		cpuWe = we;
		cpuAddr = addr;
		cpuWData = wData;
		waitCycles = 0;
		do begin
			stepCycle();
			waitCycles++;
		end while (!cpuAck && waitCycles < 8);
		// Slot wait plus capture takes six cycles at most
		assert (cpuAck && waitCycles <= 6) else begin
			protocolErrors++;
			$display("cpuAck took %0d cycles or never rose", waitCycles);
		end
		rData = cpuRData;
		repeat (holdCycles) begin
			stepCycle();
			assert (cpuAck) else begin
				protocolErrors++;
				$display("cpuAck dropped while cpuReq was still held");
			end
		end
		cpuReq = 1'b0;
		waitCycles = 0;
		do begin
			stepCycle();
			waitCycles++;
		end while (cpuAck && waitCycles < 4);
		assert (!cpuAck) else begin
			protocolErrors++;
			$display("cpuAck stayed high after cpuReq was released");
		end
	endtask

	// Hold flip, drain the pipeline, then check one frame
	task automatic runFrameCheck(input logic flipVal);
		stepCycle();
		flip = flipVal;
		repeat (4) stepCycle();
		checkOn = 1'b1;
		repeat (frameCycles) stepCycle();
		checkOn = 1'b0;
	endtask

	task automatic reportAndFinish();
		$display("Error counts: value %0d, protocol %0d, timeout %0d",
			valueErrors, protocolErrors, timedOut);
		if (valueErrors == 0 && protocolErrors == 0 && !timedOut)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	//////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////

	// Outputs settle by the falling edge
	always @(negedge clk6M) begin
		// Syncs follow the sync windows one pixel late
		if (rstN && prevSeen) begin
			expHSyncN = (prevH < `HSYNC_START) || (prevH >= `HSYNC_END);
			expVSyncN = (prevV < `VSYNC_START) || (prevV >= `VSYNC_END);
			assert (hSyncN == expHSyncN) else begin
				valueErrors++;
				$display("error hSyncN got %h expected %h", hSyncN, expHSyncN);
			end
			assert (vSyncN == expVSyncN) else begin
				valueErrors++;
				$display("error vSyncN got %h expected %h", vSyncN, expVSyncN);
			end
		end
		prevH = hCount;
		prevV = vCount;
		prevSeen = rstN;
		if (rstN && ramWe) begin
			weCycles++;
			assert (hCount[1:0] == `SLOT_CPU) else begin
				protocolErrors++;
				$display("ramWe was high outside the CPU slot, hCount %h", hCount);
			end
		end
		if (rstN && checkOn && gfxValid) begin
			gfxChecks++;
			// Fetch was two pixels back on the same line
			expected = expectedFetch(gfxLayer, beamPos'(hCount - 9'd2), vCount, flip);
			assert (hCount[1:0] == {1'b1, gfxLayer}) else begin
				valueErrors++;
				$display("error gfxLayer got %h in slot %h", gfxLayer, hCount[1:0]);
			end
			assert (gfxOut == expected[18:5]) else begin
				valueErrors++;
				$display("error gfxOut got %h expected %h", gfxOut, expected[18:5]);
			end
			assert (colorOut == expected[4:0]) else begin
				valueErrors++;
				$display("error colorOut got %h expected %h", colorOut, expected[4:0]);
			end
		end
	end

	// Cycle limit
	initial begin
		cycleCount = 0;
		timedOut = 1'b0;
		while (cycleCount < maxCycles) begin
			@(posedge clk6M);
			cycleCount++;
		end
		timedOut = 1'b1;
		$display("Run did not complete within %0d cycles", maxCycles);
		reportAndFinish();
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		tileWord rd;
		tileWord data;
		tileAddr addr;
		int n;
		int writesBefore;
		seed = 64;
		flip = 1'b0;
		cpuReq = 1'b0;
		cpuRegSel = 1'b0;
		cpuWe = 1'b0;
		cpuAddr = '0;
		cpuWData = '0;
		checkOn = 1'b0;
		prevSeen = 1'b0;
		valueErrors = 0;
		protocolErrors = 0;
		gfxChecks = 0;
		weCycles = 0;
		ramWrites = 0;
		shadowX = '{default: '0};
		shadowY = '{default: '0};
		regValue = '{16'h00a5, 16'h003c, 16'h01d3, 16'h00c7};
		for (int i = 0; i < 4096; i++)
			u_ram.mem[i] = tileWord'($random(seed));

		// Reset state and first result
		@(posedge rstN);
		@(negedge clk6M);
		assert (!cpuAck && !ramWe && !gfxValid) else begin
			protocolErrors++;
			$display("cpuAck, ramWe or gfxValid was high after reset");
		end
		n = 0;
		while (!gfxValid && n < 8) begin
			@(negedge clk6M);
			n++;
		end
		assert (gfxValid && gfxLayer == 1'b0) else begin
			valueErrors++;
			$display("error gfxLayer got %h expected 0 on first gfxValid %h", gfxLayer, gfxValid);
		end

		// Scroll registers written then read back
		for (int r = 0; r < 4; r++) begin
			cpuAccess(1'b1, 1'b1, tileAddr'(r), regValue[r], 0, rd);
			if (r[0])
				shadowY[r[1]] = regValue[r][7:0];
			else
				shadowX[r[1]] = regValue[r][8:0];
		end
		for (int r = 0; r < 4; r++) begin
			cpuAccess(1'b1, 1'b0, tileAddr'(r), '0, 0, rd);
			data = r[0] ? {8'd0, shadowY[r[1]]} : {7'd0, shadowX[r[1]]};
			assert (rd == data) else begin
				valueErrors++;
				$display("error cpuRData reg %0d got %h expected %h", r, rd, data);
			end
		end

		// Tile RAM with one address per top-bit group
		for (int i = 0; i < 8; i++) begin
			addr = {i[2:0], 9'($random(seed))};
			data = tileWord'($random(seed));
			cpuAccess(1'b0, 1'b1, addr, data, 0, rd);
			ramWrites++;
			cpuAccess(1'b0, 1'b0, addr, '0, 0, rd);
			assert (rd == data) else begin
				valueErrors++;
				$display("error cpuRData addr %h got %h expected %h", addr, rd, data);
			end
		end

		// Normal frame then flipped frame
		runFrameCheck(1'b0);
		runFrameCheck(1'b1);

		// Long hold after ack
		writesBefore = u_ram.writeCount;
		cpuAccess(1'b0, 1'b1, 12'h5a5, 16'hbeef, 20, rd);
		ramWrites++;
		stepCycle();
		assert (u_ram.writeCount == writesBefore + 1) else begin
			protocolErrors++;
			$display("Held request caused %0d RAM writes instead of one",
				u_ram.writeCount - writesBefore);
		end
		assert (weCycles == ramWrites) else begin
			protocolErrors++;
			$display("ramWe was high in %0d cycles for %0d writes", weCycles, ramWrites);
		end
		// Two results per four pixels over two frames
		assert (gfxChecks == frameCycles) else begin
			protocolErrors++;
			$display("Only %0d graphics results were checked", gfxChecks);
		end
		reportAndFinish();
	end

endmodule

/* tests/tileRamModel.sv */
`timescale 1ns/1ps

module tileRamModel import tilemapPkg::*; (
	input  logic    clk6M,
	input  tileAddr addr,
	input  logic    we,
	input  tileWord wData,
	output tileWord rData
);

	// 4096 words, filled by the bench
	tileWord mem [0:4095];

	// Writes seen on the bus
	int writeCount = 0;

	// One cycle read latency, read returns the old word on a write
	always @(posedge clk6M) begin
		if (we) begin
			mem[addr] <= wData;
			writeCount <= writeCount + 1;
		end
		rData <= mem[addr];
	end

endmodule

/* tilemapGen.f */
+incdir+src
src/tilemapPkg.sv
src/videoTiming.sv
src/tileLayer.sv
src/cpuPort.sv
src/tilemapGen.sv
tests/clkGen.sv
tests/tileRamModel.sv
tests/tbTilemapGen.sv
